// ==== hdl/obi_pkg.sv ====
`default_nettype none

package obi_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------

    // Byte addresses on both ports, word-sized data
    localparam int OBI_ADDR_W = 32;
    localparam int OBI_DATA_W = 32;

    // One byte enable per data byte
    localparam int OBI_BE_W = OBI_DATA_W / 8;

    // ------------------------------
    // Channel types
    // ------------------------------

    // Manager to subordinate, address phase fields plus the response ready
    // The fields are held stable from req until gnt
    typedef struct packed {
        logic                  req;
        logic                  we;
        logic [OBI_BE_W-1:0]   be;
        logic [OBI_ADDR_W-1:0] addr;
        logic [OBI_DATA_W-1:0] wdata;
        logic                  rready;
    } obi_req_t;

    // Subordinate to manager, grant plus the response phase fields
    // rvalid comes one cycle after the grant in this system
    typedef struct packed {
        logic                  gnt;
        logic                  rvalid;
        logic [OBI_DATA_W-1:0] rdata;
        logic                  err;
    } obi_rsp_t;

endpackage : obi_pkg

`default_nettype wire

// ==== hdl/acc_core_pkg.sv ====
`default_nettype none

package acc_core_pkg;

    // Word memory shared by program and data
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = 8;

    // Instruction layout: opcode in the top byte, immediate in the low half
    // The immediate is a byte address for LD, ADD, ST and JMP
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 24;
    localparam int IMM_W   = 16;

    // Opcodes in the top byte, every other value is illegal
    typedef enum logic [7:0] {
        OP_LDI  = 8'h01,
        OP_LD   = 8'h02,
        OP_ADD  = 8'h03,
        OP_ST   = 8'h04,
        OP_JMP  = 8'h05,
        OP_HALT = 8'h06
    } acc_opcode_e;

    // Core sequencer states
    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_FETCH      = 3'd1,
        ST_FETCH_WAIT = 3'd2,
        ST_EXEC       = 3'd3,
        ST_MEM_WAIT   = 3'd4,
        ST_HALTED     = 3'd5
    } core_state_e;

endpackage : acc_core_pkg

`default_nettype wire

// ==== hdl/acc_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module acc_core
    import obi_pkg::*;
    import acc_core_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  fetch_en_i,
    output logic                  instr_req_o,
    output logic [OBI_ADDR_W-1:0] instr_addr_o,
    input  obi_rsp_t              instr_rsp_i,
    output obi_req_t              data_req_o,
    input  obi_rsp_t              data_rsp_i,
    output core_state_e           state_o,
    output logic [OBI_ADDR_W-1:0] pc_o,
    output logic                  illegal_o
);

    core_state_e           state_q;
    logic [OBI_ADDR_W-1:0] pc_q;
    logic [OBI_DATA_W-1:0] acc_q;
    logic [OBI_DATA_W-1:0] ir_q;
    logic                  illegal_q;
    obi_req_t              data_req_q;

    acc_opcode_e           opcode;
    logic [OBI_ADDR_W-1:0] imm_ext;
    logic [OBI_ADDR_W-1:0] pc_next;

    // ------------------------------
    // Decode
    // ------------------------------

    // Opcode and zero-extended immediate of the held instruction
    assign opcode  = acc_opcode_e'(ir_q[OPC_MSB:OPC_LSB]);
    assign imm_ext = {{(OBI_ADDR_W-IMM_W){1'b0}}, ir_q[IMM_W-1:0]};

    // Sequential pc steps one word, so four bytes
    assign pc_next = pc_q + OBI_ADDR_W'(OBI_BE_W);

    // Instruction word is captured when the fetch response arrives
    always_ff @(posedge clk_i) begin
        if (state_q == ST_FETCH_WAIT && instr_rsp_i.rvalid) begin
            ir_q <= instr_rsp_i.rdata;
        end
    end

    // ------------------------------
    // Sequencer
    // ------------------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= ST_IDLE;
            pc_q       <= '0;
            acc_q      <= '0;
            illegal_q  <= 1'b0;
            data_req_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (fetch_en_i) begin
                        state_q <= ST_FETCH;
                    end
                end
                // Fetch request is held until the memory grants it
                ST_FETCH: begin
                    if (instr_rsp_i.gnt) begin
                        state_q <= ST_FETCH_WAIT;
                    end
                end
                ST_FETCH_WAIT: begin
                    if (instr_rsp_i.rvalid) begin
                        state_q <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    case (opcode)
                        OP_LDI: begin
                            acc_q   <= imm_ext;
                            pc_q    <= pc_next;
                            state_q <= ST_FETCH;
                        end
                        // Memory ops launch the data request on the next cycle
                        OP_LD, OP_ADD, OP_ST: begin
                            data_req_q.req   <= 1'b1;
                            data_req_q.we    <= (opcode == OP_ST);
                            data_req_q.be    <= '1;
                            data_req_q.addr  <= imm_ext;
                            data_req_q.wdata <= acc_q;
                            state_q          <= ST_MEM_WAIT;
                        end
                        OP_JMP: begin
                            pc_q    <= imm_ext;
                            state_q <= ST_FETCH;
                        end
                        // pc stays on the HALT word
                        OP_HALT: begin
                            state_q <= ST_HALTED;
                        end
                        default: begin
                            illegal_q <= 1'b1;
                            state_q   <= ST_HALTED;
                        end
                    endcase
                end
                // First the request waits for gnt, then the response for rvalid
                ST_MEM_WAIT: begin
                    if (data_req_q.req) begin
                        if (data_rsp_i.gnt) begin
                            data_req_q.req <= 1'b0;
                        end
                    end else if (data_rsp_i.rvalid) begin
                        if (opcode == OP_LD) begin
                            acc_q <= data_rsp_i.rdata;
                        end else if (opcode == OP_ADD) begin
                            acc_q <= acc_q + data_rsp_i.rdata;
                        end
                        pc_q    <= pc_next;
                        state_q <= ST_FETCH;
                    end
                end
                // Only reset leaves the halted state
                ST_HALTED: begin
                    state_q <= ST_HALTED;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Instruction port carries only req and addr, the wrapper adds the rest
    assign instr_req_o  = (state_q == ST_FETCH);
    assign instr_addr_o = pc_q;
    assign data_req_o   = data_req_q;
    assign state_o      = state_q;
    assign pc_o         = pc_q;
    assign illegal_o    = illegal_q;

endmodule : acc_core

`default_nettype wire

// ==== hdl/obi_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module obi_sram
    import obi_pkg::*;
    import acc_core_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  obi_req_t              ia_req_i,
    output obi_rsp_t              ia_rsp_o,
    input  obi_req_t              da_req_i,
    output obi_rsp_t              da_rsp_o,
    input  logic                  load_we_i,
    input  logic [MEM_AW-1:0]     load_addr_i,
    input  logic [OBI_DATA_W-1:0] load_data_i,
    input  logic [MEM_AW-1:0]     rd_addr_i,
    output logic [OBI_DATA_W-1:0] rd_data_o
);

    localparam int NPORTS = 2;

    logic [OBI_DATA_W-1:0] mem_q [MEM_WORDS];

    // Port 0 is the instruction side, port 1 the data side
    obi_req_t              port_req [NPORTS];
    logic [NPORTS-1:0]     rvalid_q;
    logic [OBI_DATA_W-1:0] rdata_q  [NPORTS];

    assign port_req[0] = ia_req_i;
    assign port_req[1] = da_req_i;

    // Byte address to word index, upper bits beyond the depth are dropped
    function automatic logic [MEM_AW-1:0] word_idx(input logic [OBI_ADDR_W-1:0] addr);
        return addr[MEM_AW+1:2];
    endfunction

    // ------------------------------
    // Array writes
    // ------------------------------

    // Later writes in the loop win, so the data port beats the instruction port
    // The load strobe is applied last of all
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < NPORTS; p++) begin
            if (port_req[p].req && port_req[p].we) begin
                for (int b = 0; b < OBI_BE_W; b++) begin
                    if (port_req[p].be[b]) begin
                        mem_q[word_idx(port_req[p].addr)][8*b +: 8] <= port_req[p].wdata[8*b +: 8];
                    end
                end
            end
        end
        if (load_we_i) begin
            mem_q[load_addr_i] <= load_data_i;
        end
    end

    // ------------------------------
    // Responses
    // ------------------------------

    // Every request is granted at once, so rvalid is the request delayed
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rvalid_q <= '0;
        end else begin
            for (int p = 0; p < NPORTS; p++) begin
                rvalid_q[p] <= port_req[p].req;
            end
        end
    end

    // Read data is the word before any write of the same edge
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < NPORTS; p++) begin
            if (port_req[p].req) begin
                rdata_q[p] <= mem_q[word_idx(port_req[p].addr)];
            end
        end
    end

    always_comb begin
        ia_rsp_o.gnt    = ia_req_i.req;
        ia_rsp_o.rvalid = rvalid_q[0];
        ia_rsp_o.rdata  = rdata_q[0];
        ia_rsp_o.err    = 1'b0;
        da_rsp_o.gnt    = da_req_i.req;
        da_rsp_o.rvalid = rvalid_q[1];
        da_rsp_o.rdata  = rdata_q[1];
        da_rsp_o.err    = 1'b0;
    end

    // Readback for the testbench, no clock involved
    assign rd_data_o = mem_q[rd_addr_i];

endmodule : obi_sram

`default_nettype wire

// ==== hdl/acc_core_wrap.sv ====
`timescale 1ns/1ps
`default_nettype none

module acc_core_wrap
    import obi_pkg::*;
    import acc_core_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  fetch_en_i,
    output obi_req_t              instr_req_o,
    input  obi_rsp_t              instr_rsp_i,
    output obi_req_t              data_req_o,
    input  obi_rsp_t              data_rsp_i,
    output logic                  havereset_o,
    output logic                  running_o,
    output logic                  halted_o,
    output logic                  alert_o,
    output logic [OBI_ADDR_W-1:0] pc_o
);

    logic                  core_instr_req;
    logic [OBI_ADDR_W-1:0] core_instr_addr;
    obi_req_t              core_data_req;
    core_state_e           core_state;
    logic                  core_illegal;
    logic                  havereset_q;

    acc_core core_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .fetch_en_i   (fetch_en_i),
        .instr_req_o  (core_instr_req),
        .instr_addr_o (core_instr_addr),
        .instr_rsp_i  (instr_rsp_i),
        .data_req_o   (core_data_req),
        .data_rsp_i   (data_rsp_i),
        .state_o      (core_state),
        .pc_o         (pc_o),
        .illegal_o    (core_illegal)
    );

    // ------------------------------
    // OBI tie-offs
    // ------------------------------

    always_comb begin
        // Instruction side only ever reads full words
        instr_req_o.req    = core_instr_req;
        instr_req_o.we     = 1'b0;
        instr_req_o.be     = '1;
        instr_req_o.addr   = core_instr_addr;
        instr_req_o.wdata  = '0;
        instr_req_o.rready = 1'b1;
        // Data side passes through, responses are always accepted
        data_req_o         = core_data_req;
        data_req_o.rready  = 1'b1;
    end

    // ------------------------------
    // Debug status
    // ------------------------------

    // Set by reset, cleared for good by the first granted fetch
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            havereset_q <= 1'b1;
        end else if (core_instr_req && instr_rsp_i.gnt) begin
            havereset_q <= 1'b0;
        end
    end

    assign havereset_o = havereset_q;
    assign running_o   = (core_state != ST_IDLE) && (core_state != ST_HALTED);
    assign halted_o    = (core_state == ST_HALTED);
    // The illegal flag and the halted state are set on the same edge
    assign alert_o     = core_illegal;

endmodule : acc_core_wrap

`default_nettype wire

// ==== hdl/acc_sys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module acc_sys_top
    import obi_pkg::*;
    import acc_core_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  fetch_en_i,
    input  logic                  load_we_i,
    input  logic [MEM_AW-1:0]     load_addr_i,
    input  logic [OBI_DATA_W-1:0] load_data_i,
    input  logic [MEM_AW-1:0]     rd_addr_i,
    output logic [OBI_DATA_W-1:0] rd_data_o,
    output logic                  havereset_o,
    output logic                  running_o,
    output logic                  halted_o,
    output logic                  alert_o,
    output logic [OBI_ADDR_W-1:0] pc_o
);

    // Both OBI ports run point to point, no interconnect in between
    obi_req_t instr_req;
    obi_rsp_t instr_rsp;
    obi_req_t data_req;
    obi_rsp_t data_rsp;

    acc_core_wrap core_wrap_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .fetch_en_i  (fetch_en_i),
        .instr_req_o (instr_req),
        .instr_rsp_i (instr_rsp),
        .data_req_o  (data_req),
        .data_rsp_i  (data_rsp),
        .havereset_o (havereset_o),
        .running_o   (running_o),
        .halted_o    (halted_o),
        .alert_o     (alert_o),
        .pc_o        (pc_o)
    );

    obi_sram sram_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .ia_req_i    (instr_req),
        .ia_rsp_o    (instr_rsp),
        .da_req_i    (data_req),
        .da_rsp_o    (data_rsp),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .rd_addr_i   (rd_addr_i),
        .rd_data_o   (rd_data_o)
    );

endmodule : acc_sys_top

`default_nettype wire

// ==== dv/acc_sys_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module acc_sys_chk
    import obi_pkg::*;
(
    input logic     clk_i,
    input logic     rst_n_i,
    input obi_req_t instr_req_i,
    input obi_rsp_t instr_rsp_i,
    input obi_req_t data_req_i,
    input obi_rsp_t data_rsp_i,
    input logic     havereset_i,
    input logic     halted_i,
    input logic     alert_i
);

    // Instruction fetches only ever read
    instr_read_only: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !instr_req_i.we)
        else $error("instruction request with we set");

    // The memory grants at once and answers exactly one cycle later
    instr_rvalid_delay: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_rsp_i.rvalid == $past(instr_req_i.req && instr_rsp_i.gnt))
        else $error("instruction rvalid not one cycle after the grant");

    data_rvalid_delay: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_rsp_i.rvalid == $past(data_req_i.req && data_rsp_i.gnt))
        else $error("data rvalid not one cycle after the grant");

    // An illegal opcode always ends in the halted state
    alert_halted: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        alert_i |-> halted_i)
        else $error("alert without halted");

    // Only reset may set the flag again
    havereset_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$rose(havereset_i))
        else $error("havereset rose while out of reset");

endmodule : acc_sys_chk

bind acc_core_wrap acc_sys_chk chk_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .instr_req_i (instr_req_o),
    .instr_rsp_i (instr_rsp_i),
    .data_req_i  (data_req_o),
    .data_rsp_i  (data_rsp_i),
    .havereset_i (havereset_o),
    .halted_i    (halted_o),
    .alert_i     (alert_o)
);

`default_nettype wire

// ==== dv/tb_acc_sys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_acc_sys
    import obi_pkg::*;
    import acc_core_pkg::*;
();

    localparam int          CLK_PERIOD = 40;
    localparam logic [31:0] LFSR_SEED  = 32'hd5ea_7183;
    // The four program tests execute 3, 4, 3 and 1 instructions
    localparam int          INSTR_TOTAL = 11;
    // Each instruction takes at most 5 cycles and the margin covers resets and program loads
    localparam int          WD_CYCLES   = INSTR_TOTAL * 5 + 200;

    logic                  clk;
    logic                  rst_n;
    logic                  fetch_en;
    logic                  load_we;
    logic [MEM_AW-1:0]     load_addr;
    logic [OBI_DATA_W-1:0] load_data;
    logic [MEM_AW-1:0]     rd_addr;
    logic [OBI_DATA_W-1:0] rd_data;
    logic                  havereset;
    logic                  running;
    logic                  halted;
    logic                  alert;
    logic [OBI_ADDR_W-1:0] pc;

    logic [31:0]           lfsr_q;
    // Program words of the current test are kept for the integrity readback
    logic [MEM_AW-1:0]     prog_idx  [$];
    logic [OBI_DATA_W-1:0] prog_word [$];

    acc_sys_top dut_i (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .fetch_en_i  (fetch_en),
        .load_we_i   (load_we),
        .load_addr_i (load_addr),
        .load_data_i (load_data),
        .rd_addr_i   (rd_addr),
        .rd_data_o   (rd_data),
        .havereset_o (havereset),
        .running_o   (running),
        .halted_o    (halted),
        .alert_o     (alert),
        .pc_o        (pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    // All stimulus changes land 2 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            fail_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            fail_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit taken
    function automatic logic [31:0] random_word();
        logic        fb;
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < 32; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            word   = {word[30:0], fb};
        end
        return word;
    endfunction

    // Opcode in the top byte and the 16-bit immediate at the bottom with a zero byte between
    function automatic logic [31:0] encode(input logic [7:0] op, input logic [IMM_W-1:0] imm);
        return {op, 8'h00, imm};
    endfunction

    // The core addresses bytes while the memory holds words
    function automatic logic [IMM_W-1:0] word_addr(input logic [MEM_AW-1:0] idx);
        return IMM_W'({idx, 2'b00});
    endfunction

    task automatic apply_reset();
        fetch_en = 1'b0;
        rst_n    = 1'b0;
        repeat (2) step();
        rst_n    = 1'b1;
    endtask

    // One word per load strobe
    task automatic load_word(input logic [MEM_AW-1:0] idx, input logic [31:0] data);
        load_we   = 1'b1;
        load_addr = idx;
        load_data = data;
        step();
        load_we   = 1'b0;
    endtask

    task automatic clear_program();
        prog_idx.delete();
        prog_word.delete();
    endtask

    task automatic load_instr(input logic [MEM_AW-1:0] idx, input logic [31:0] data);
        prog_idx.push_back(idx);
        prog_word.push_back(data);
        load_word(idx, data);
    endtask

    // The readback port is combinational, so a short settle is enough
    task automatic read_word(input logic [MEM_AW-1:0] idx, output logic [31:0] data);
        rd_addr = idx;
        #1;
        data = rd_data;
    endtask

    // A one-cycle fetch_en pulse starts the core and halted_o ends the program
    task automatic run_program();
        fetch_en = 1'b1;
        step();
        fetch_en = 1'b0;
        // The core counts as running from the first fetch until it halts
        while (!halted) begin
            check_bit("running_o", running, 1'b1);
            step();
        end
        check_bit("running_o", running, 1'b0);
    endtask

    // Instruction-port tie-offs must never have written the program area
    task automatic check_program();
        logic [31:0] got;
        for (int i = 0; i < prog_idx.size(); i++) begin
            read_word(prog_idx[i], got);
            check_eq($sformatf("mem[%0h]", prog_idx[i]), got, prog_word[i]);
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic test_reset_state();
        apply_reset();
        check_bit("havereset_o", havereset, 1'b1);
        check_bit("running_o", running, 1'b0);
        check_bit("halted_o", halted, 1'b0);
        check_bit("alert_o", alert, 1'b0);
        check_eq("pc_o", pc, 32'h0000_0000);
    endtask

    // The immediate has its top bit set to show the zero extension
    task automatic test_store_imm();
        logic [31:0] got;
        apply_reset();
        load_word(8'h40, 32'hffff_ffff);
        clear_program();
        load_instr(8'd0, encode(OP_LDI, 16'hc35a));
        load_instr(8'd1, encode(OP_ST, word_addr(8'h40)));
        load_instr(8'd2, encode(OP_HALT, 16'h0000));
        run_program();
        read_word(8'h40, got);
        check_eq("mem[40]", got, 32'h0000_c35a);
        check_bit("havereset_o", havereset, 1'b0);
        // A legal HALT must not raise the alert
        check_bit("alert_o", alert, 1'b0);
        check_eq("pc_o", pc, 32'h0000_0008);
        check_program();
    endtask

    task automatic test_accumulate();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] got;
        apply_reset();
        a = random_word();
        b = random_word();
        load_word(8'h41, a);
        load_word(8'h42, b);
        clear_program();
        load_instr(8'd0, encode(OP_LD, word_addr(8'h41)));
        load_instr(8'd1, encode(OP_ADD, word_addr(8'h42)));
        load_instr(8'd2, encode(OP_ST, word_addr(8'h43)));
        load_instr(8'd3, encode(OP_HALT, 16'h0000));
        run_program();
        read_word(8'h43, got);
        // Sum wraps at 32 bits
        check_eq("mem[43]", got, a + b);
        check_eq("pc_o", pc, 32'h0000_000c);
        check_program();
    endtask

    // Falling through would store and halt at word 3 instead of word 4
    task automatic test_jump();
        logic [31:0] keep;
        logic [31:0] got;
        apply_reset();
        keep = random_word();
        load_word(8'h44, keep);
        clear_program();
        load_instr(8'd0, encode(OP_LDI, 16'h1234));
        load_instr(8'd1, encode(OP_JMP, word_addr(8'd4)));
        load_instr(8'd2, encode(OP_ST, word_addr(8'h44)));
        load_instr(8'd3, encode(OP_HALT, 16'h0000));
        load_instr(8'd4, encode(OP_HALT, 16'h0000));
        run_program();
        read_word(8'h44, got);
        check_eq("mem[44]", got, keep);
        check_eq("pc_o", pc, 32'h0000_0010);
        check_program();
    endtask

    task automatic test_illegal();
        logic [31:0] keep;
        logic [31:0] got;
        apply_reset();
        keep = random_word();
        load_word(8'h45, keep);
        clear_program();
        load_instr(8'd0, encode(8'hff, word_addr(8'h45)));
        load_instr(8'd1, encode(OP_ST, word_addr(8'h45)));
        run_program();
        check_bit("alert_o", alert, 1'b1);
        check_bit("halted_o", halted, 1'b1);
        check_bit("running_o", running, 1'b0);
        read_word(8'h45, got);
        check_eq("mem[45]", got, keep);
        check_program();
    endtask

    // ------------------------------
    // Run control
    // ------------------------------

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        fail_run("timeout: the tests did not finish within the watchdog limit");
    end

    initial begin
        rst_n     = 1'b0;
        fetch_en  = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        rd_addr   = '0;
        lfsr_q    = LFSR_SEED;
        test_reset_state();
        test_store_imm();
        test_accumulate();
        test_jump();
        test_illegal();
        $display("Finished with no errors");
        $finish;
    end

endmodule : tb_acc_sys

`default_nettype wire

// ==== all.f ====
hdl/obi_pkg.sv
hdl/acc_core_pkg.sv
hdl/acc_core.sv
hdl/obi_sram.sv
hdl/acc_core_wrap.sv
hdl/acc_sys_top.sv
dv/acc_sys_chk.sv
dv/tb_acc_sys.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_acc_sys
FILELIST   := all.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
PASS_MSG   := Finished with no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
